//--- Bender.yml
package:
  name: dircc_processing

sources:
  - source/dircc_pkg.sv
  - source/dircc_packet_receiver.sv
  - source/dircc_packet_sender.sv
  - source/dircc_status_register.sv
  - source/dircc_receive_handler.sv
  - source/dircc_send_handler.sv
  - source/dircc_processing.sv
  - target: simulation
    files:
      - tb/dircc_processing_chk.sv
      - tb/dircc_processing_tb.sv

//--- source/dircc_packet_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module dircc_packet_receiver
    import dircc_pkg::*;
(
    input  wire           clk,
    input  wire           reset_n,

    input  wire beat_t    input_data,
    input  wire           input_startofpacket,
    input  wire           input_endofpacket,
    input  wire           input_valid,
    output logic          input_ready,

    input  wire           booting,

    output packet_t       packet_in,
    output logic          receive_done
);

    rx_state_t state;
    beat_cnt_t beat_cnt;
    beat_cnt_t beat_idx;
    logic      beat_fire;
    logic      store_beat;

    assign input_ready  = !booting && (state != RX_HOLD);
    assign receive_done = (state == RX_HOLD); // Lasts exactly one cycle

    assign beat_fire  = input_valid && input_ready;
    assign store_beat = beat_fire && (input_startofpacket || state == RX_BODY);
    assign beat_idx   = input_startofpacket ? '0 : beat_cnt;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= RX_IDLE;
            beat_cnt <= '0;
        end else if (state == RX_HOLD) begin
            state <= RX_IDLE; // Consumed by the top level this cycle
        end else if (beat_fire) begin
            if (input_startofpacket) begin
                // SOP restarts even mid-packet
                state    <= input_endofpacket ? RX_IDLE : RX_BODY;
                beat_cnt <= beat_cnt_t'(1);
            end else if (state == RX_BODY) begin
                if (beat_cnt == LAST_BEAT) begin
                    state <= input_endofpacket ? RX_HOLD : RX_IDLE;
                end else if (input_endofpacket) begin
                    state <= RX_IDLE; // Short packet dropped
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_beat) begin
            case (beat_idx)
                2'd0:    packet_in.dest_addr <= input_data;
                2'd1:    packet_in.src_addr  <= input_data;
                2'd2:    packet_in.lamport   <= input_data;
                default: packet_in.data      <= input_data;
            endcase
        end
    end

endmodule : dircc_packet_receiver

`default_nettype wire

//--- source/dircc_packet_sender.sv
`timescale 1ns/1ps
`default_nettype none

module dircc_packet_sender
    import dircc_pkg::*;
(
    input  wire           clk,
    input  wire           reset_n,

    input  wire           write_packet,
    input  wire packet_t  packet_out,

    output beat_t         output_data,
    output logic          output_startofpacket,
    output logic          output_endofpacket,
    output logic          output_valid,
    input  wire           output_ready,

    output logic          sending
);

    tx_state_t state;
    beat_cnt_t beat_cnt;
    packet_t   packet_q;

    assign sending              = (state == TX_SEND);
    assign output_valid         = (state == TX_SEND);
    assign output_startofpacket = output_valid && (beat_cnt == '0);
    assign output_endofpacket   = output_valid && (beat_cnt == LAST_BEAT);

    // Beat select from the held packet, so stalls keep it stable
    always_comb begin
        case (beat_cnt)
            2'd0:    output_data = packet_q.dest_addr;
            2'd1:    output_data = packet_q.src_addr;
            2'd2:    output_data = packet_q.lamport;
            default: output_data = packet_q.data;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= TX_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (write_packet) begin
                        state    <= TX_SEND;
                        beat_cnt <= '0;
                    end
                end
                TX_SEND: begin
                    if (output_ready) begin
                        if (beat_cnt == LAST_BEAT) begin
                            state <= TX_IDLE;
                        end
                        beat_cnt <= beat_cnt + 1'b1; // Wraps to 0 after the last beat
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (write_packet) begin
            packet_q <= packet_out;
        end
    end

endmodule : dircc_packet_sender

`default_nettype wire

//--- source/dircc_pkg.sv
`default_nettype none

package dircc_pkg;

    typedef logic [31:0] beat_t;
    typedef logic [14:0] mem_addr_t;
    typedef logic [15:0] mem_data_t;
    typedef logic [31:0] hw_addr_t;
    typedef logic [31:0] lamport_t;
    typedef logic [31:0] packet_data_t;

    // Field order is wire order, dest_addr leaves first
    typedef struct packed {
        hw_addr_t     dest_addr;
        hw_addr_t     src_addr;
        lamport_t     lamport;
        packet_data_t data;
    } packet_t;

    typedef struct packed {
        logic [15:0] dircc_state;
        logic [15:0] dircc_state_extra;
        logic [15:0] user_state;
    } device_state_t;

    localparam logic [15:0] DIRCC_STATE_BOOTED  = 16'h0001;
    localparam logic [15:0] DIRCC_STATE_RUNNING = 16'h0002;
    localparam logic [15:0] DIRCC_STATE_STOPPED = 16'h0004;
    localparam logic [15:0] DIRCC_STATE_ERROR   = 16'h0008;

    localparam int PENDING_BIT = 0; // Unsent result in dircc_state_extra

    localparam int BEATS_PER_PACKET = 4;
    typedef logic [$clog2(BEATS_PER_PACKET)-1:0] beat_cnt_t;
    localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(BEATS_PER_PACKET - 1);

    localparam int RTS_READY_WIDTH = 8;

    localparam logic [7:0] DEVICE_ID = 8'h05; // sw address in src_addr[7:0]

    // Port 0 destinations
    localparam int NUM_TARGETS = 3;
    typedef logic [$clog2(NUM_TARGETS)-1:0] target_idx_t;
    localparam target_idx_t LAST_TARGET = target_idx_t'(NUM_TARGETS - 1);
    localparam hw_addr_t TARGET_TABLE [NUM_TARGETS] = '{
        32'h0000_0101,
        32'h0000_0202,
        32'h0000_0303
    };

    // Host map
    localparam mem_addr_t REG_STATE = 15'd0;
    localparam mem_addr_t REG_EXTRA = 15'd1;
    localparam mem_addr_t REG_USER  = 15'd2;

    typedef enum logic [1:0] {
        RX_IDLE, // Waiting for startofpacket
        RX_BODY,
        RX_HOLD  // Packet complete, ready low
    } rx_state_t;

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } tx_state_t;

endpackage : dircc_pkg

`default_nettype wire

//--- source/dircc_processing.sv
`timescale 1ns/1ps
`default_nettype none

module dircc_processing
    import dircc_pkg::*;
(
    input  wire             clk,
    input  wire             reset_n,

    input  wire hw_addr_t   address,

    input  wire beat_t      input_data,
    input  wire             input_startofpacket,
    input  wire             input_endofpacket,
    input  wire             input_valid,
    output logic            input_ready,

    output beat_t           output_data,
    output logic            output_startofpacket,
    output logic            output_endofpacket,
    output logic            output_valid,
    input  wire             output_ready,

    input  wire mem_addr_t  mem_address,
    input  wire             mem_write,
    input  wire mem_data_t  mem_writedata,
    output mem_data_t       mem_readdata
);

    logic                       booting;
    logic                       receive_done;
    logic                       sending;
    logic                       write_packet;
    packet_t                    packet_in;
    packet_t                    packet_out;

    device_state_t              read_state;
    device_state_t              write_state;
    logic                       write_state_valid;
    device_state_t              rx_write_state;
    device_state_t              tx_write_state;
    logic [RTS_READY_WIDTH-1:0] rts_ready;
    packet_data_t               tx_payload;

    lamport_t                   lamport;
    lamport_t                   lamport_max;
    lamport_t                   send_lamport; // Value after the send-handler call
    packet_data_t               send_data;

    logic                       fanout_active;
    target_idx_t                target_idx;

    logic running;
    logic stopped;
    logic rx_call;
    logic tx_call;
    logic drop_packet;
    logic fanout_issue;

    dircc_packet_receiver i_packet_receiver (
        .clk                 (clk),
        .reset_n             (reset_n),
        .input_data          (input_data),
        .input_startofpacket (input_startofpacket),
        .input_endofpacket   (input_endofpacket),
        .input_valid         (input_valid),
        .input_ready         (input_ready),
        .booting             (booting),
        .packet_in           (packet_in),
        .receive_done        (receive_done)
    );

    dircc_packet_sender i_packet_sender (
        .clk                  (clk),
        .reset_n              (reset_n),
        .write_packet         (write_packet),
        .packet_out           (packet_out),
        .output_data          (output_data),
        .output_startofpacket (output_startofpacket),
        .output_endofpacket   (output_endofpacket),
        .output_valid         (output_valid),
        .output_ready         (output_ready),
        .sending              (sending)
    );

    dircc_status_register i_status_register (
        .clk               (clk),
        .reset_n           (reset_n),
        .mem_address       (mem_address),
        .mem_write         (mem_write),
        .mem_writedata     (mem_writedata),
        .mem_readdata      (mem_readdata),
        .write_state       (write_state),
        .write_state_valid (write_state_valid),
        .read_state        (read_state)
    );

    dircc_receive_handler i_receive_handler (
        .read_state  (read_state),
        .packet_in   (packet_in),
        .write_state (rx_write_state)
    );

    dircc_send_handler i_send_handler (
        .read_state      (read_state),
        .rts_ready       (rts_ready),
        .packet_out_data (tx_payload),
        .write_state     (tx_write_state)
    );

    assign running = |(read_state.dircc_state & DIRCC_STATE_RUNNING);
    assign stopped = |(read_state.dircc_state & DIRCC_STATE_STOPPED);

    // Receive beats send
    assign rx_call      = running && receive_done;
    assign tx_call      = running && !receive_done && (|rts_ready) && !fanout_active;
    assign drop_packet  = !running && stopped && receive_done;
    assign fanout_issue = fanout_active && !sending && !write_packet;

    assign lamport_max = (packet_in.lamport > lamport) ? packet_in.lamport : lamport;

    always_comb begin
        write_state       = read_state;
        write_state_valid = 1'b0;
        if (rx_call) begin
            write_state       = rx_write_state;
            write_state_valid = 1'b1;
        end else if (tx_call) begin
            write_state       = tx_write_state;
            write_state_valid = 1'b1;
        end else if (drop_packet) begin
            write_state.dircc_state = read_state.dircc_state | DIRCC_STATE_ERROR;
            write_state_valid       = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            booting       <= 1'b1;
            lamport       <= '0;
            fanout_active <= 1'b0;
            target_idx    <= '0;
            write_packet  <= 1'b0;
        end else begin
            if (running || stopped) begin
                booting <= 1'b0;
            end

            if (rx_call) begin
                lamport <= lamport_max + 1'b1;
            end else if (tx_call) begin
                lamport       <= lamport + 1'b1;
                fanout_active <= 1'b1;
                target_idx    <= '0;
            end

            write_packet <= fanout_issue; // One strobe per target
            if (fanout_issue) begin
                if (target_idx == LAST_TARGET) begin
                    fanout_active <= 1'b0;
                end else begin
                    target_idx <= target_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_call) begin
            send_lamport <= lamport + 1'b1;
            send_data    <= tx_payload;
        end
        if (fanout_issue) begin
            packet_out.dest_addr <= TARGET_TABLE[target_idx];
            packet_out.src_addr  <= {address[31:8], DEVICE_ID};
            packet_out.lamport   <= send_lamport;
            packet_out.data      <= send_data;
        end
    end

endmodule : dircc_processing

`default_nettype wire

//--- source/dircc_receive_handler.sv
`timescale 1ns/1ps
`default_nettype none

module dircc_receive_handler
    import dircc_pkg::*;
(
    input  wire device_state_t  read_state,
    input  wire packet_t        packet_in,
    output device_state_t       write_state
);

    // Accumulate low half of payload and flag a pending send
    always_comb begin
        write_state            = read_state;
        write_state.user_state = read_state.user_state + packet_in.data[15:0]; // Wraps
        write_state.dircc_state_extra[PENDING_BIT] = 1'b1;
    end

endmodule : dircc_receive_handler

`default_nettype wire

//--- source/dircc_send_handler.sv
`timescale 1ns/1ps
`default_nettype none

module dircc_send_handler
    import dircc_pkg::*;
(
    input  wire device_state_t         read_state,
    output logic [RTS_READY_WIDTH-1:0] rts_ready,
    output packet_data_t               packet_out_data,
    output device_state_t              write_state
);

    // Only port 0 is ever used
    always_comb begin
        rts_ready    = '0;
        rts_ready[0] = read_state.dircc_state_extra[PENDING_BIT];
    end

    assign packet_out_data = packet_data_t'(read_state.user_state);

    always_comb begin
        write_state            = read_state;
        write_state.user_state = '0;
        write_state.dircc_state_extra[PENDING_BIT] = 1'b0;
    end

endmodule : dircc_send_handler

`default_nettype wire

//--- source/dircc_status_register.sv
`timescale 1ns/1ps
`default_nettype none

module dircc_status_register
    import dircc_pkg::*;
(
    input  wire                 clk,
    input  wire                 reset_n,

    input  wire mem_addr_t      mem_address,
    input  wire                 mem_write,
    input  wire mem_data_t      mem_writedata,
    output mem_data_t           mem_readdata,

    input  wire device_state_t  write_state,
    input  wire                 write_state_valid,
    output device_state_t       read_state
);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            read_state.dircc_state       <= DIRCC_STATE_BOOTED;
            read_state.dircc_state_extra <= '0;
            read_state.user_state        <= '0;
        end else begin
            if (write_state_valid) begin
                read_state <= write_state;
            end
            // Host write overrides its own field only
            if (mem_write) begin
                case (mem_address)
                    REG_STATE: read_state.dircc_state       <= mem_writedata;
                    REG_EXTRA: read_state.dircc_state_extra <= mem_writedata;
                    REG_USER:  read_state.user_state        <= mem_writedata;
                    default:   ;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_readdata <= '0;
        end else begin
            case (mem_address)
                REG_STATE: mem_readdata <= read_state.dircc_state;
                REG_EXTRA: mem_readdata <= read_state.dircc_state_extra;
                REG_USER:  mem_readdata <= read_state.user_state;
                default:   mem_readdata <= '0; // Unmapped
            endcase
        end
    end

endmodule : dircc_status_register

`default_nettype wire

//--- src.f
source/dircc_pkg.sv
source/dircc_packet_receiver.sv
source/dircc_packet_sender.sv
source/dircc_status_register.sv
source/dircc_receive_handler.sv
source/dircc_send_handler.sv
source/dircc_processing.sv
tb/dircc_processing_chk.sv
tb/dircc_processing_tb.sv

//--- tb/dircc_processing_chk.sv
`timescale 1ns/1ps
`default_nettype none

module dircc_processing_chk
    import dircc_pkg::*;
(
    input wire        clk,
    input wire        reset_n,
    input wire        booting,
    input wire        input_ready,
    input wire beat_t output_data,
    input wire        output_startofpacket,
    input wire        output_endofpacket,
    input wire        output_valid,
    input wire        output_ready
);

    int        assert_fails = 0;
    beat_cnt_t out_beat; // Position inside the outgoing packet

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_beat <= '0;
        end else if (output_valid && output_ready) begin
            out_beat <= out_beat + 1'b1;
        end
    end

    output_hold: assert property (@(posedge clk) disable iff (!reset_n)
        output_valid && !output_ready |=> output_valid && $stable(output_data)
            && $stable(output_startofpacket) && $stable(output_endofpacket))
        else begin
            assert_fails++;
            $error("output beat changed while stalled");
        end

    booting_blocks_input: assert property (@(posedge clk) disable iff (!reset_n)
        booting |-> !input_ready)
        else begin
            assert_fails++;
            $error("input_ready high while booting");
        end

    // One SOP, on the first of every four beats
    sop_per_packet: assert property (@(posedge clk) disable iff (!reset_n)
        output_valid && output_ready |-> output_startofpacket == (out_beat == '0))
        else begin
            assert_fails++;
            $error("startofpacket not on the first of four beats");
        end

    reset_values: assert property (@(posedge clk) !reset_n |-> !output_valid && !input_ready)
        else begin
            assert_fails++;
            $error("stream handshake active during reset");
        end

endmodule : dircc_processing_chk

`default_nettype wire

//--- tb/dircc_processing_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dircc_processing_tb
    import dircc_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_TESTS = 5;
    localparam int CYCLES_PER_TEST = 400;
    localparam int BURSTS = 3;
    localparam int BURST_LEN = 3;
    localparam int NUM_STIM = BURSTS * BURST_LEN;
    localparam hw_addr_t DEV_ADDR = 32'h4a3c_9e00;

    logic         clk;
    logic         reset_n;
    hw_addr_t     address;
    beat_t        input_data;
    logic         input_startofpacket;
    logic         input_endofpacket;
    logic         input_valid;
    logic         input_ready;
    beat_t        output_data;
    logic         output_startofpacket;
    logic         output_endofpacket;
    logic         output_valid;
    logic         output_ready;
    mem_addr_t    mem_address;
    logic         mem_write;
    mem_data_t    mem_writedata;
    mem_data_t    mem_readdata;

    packet_t      out_q[$];   // Collected from the output stream
    packet_t      exp_q[$];
    packet_t      ref_seq[$]; // Outputs of the run without back-pressure
    packet_t      out_pkt;
    lamport_t     m_lamport;
    mem_data_t    m_user;
    mem_data_t    recv_total;
    mem_data_t    sent_total;
    packet_data_t stim_data [NUM_STIM];
    lamport_t     stim_lamport [NUM_STIM];
    logic [255:0] bp_bits;
    logic [7:0]   bp_idx;
    logic         bp_en;
    int           ref_idx;
    int           errors;

    dircc_processing i_dircc_processing (.*);

    bind dircc_processing dircc_processing_chk i_chk (
        .clk                  (clk),
        .reset_n              (reset_n),
        .booting              (booting),
        .input_ready          (input_ready),
        .output_data          (output_data),
        .output_startofpacket (output_startofpacket),
        .output_endofpacket   (output_endofpacket),
        .output_valid         (output_valid),
        .output_ready         (output_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        bp_idx       <= bp_idx + 1'b1;
        output_ready <= bp_en ? bp_bits[bp_idx] : 1'b1;
    end

    always @(negedge clk) begin
        if (reset_n && output_valid && output_ready) begin
            out_pkt = {out_pkt[95:0], output_data}; // dest_addr ends up on top
            if (output_endofpacket) out_q.push_back(out_pkt);
        end
    end

    initial begin
        #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, run stopped", NUM_TESTS * CYCLES_PER_TEST);
        $display("Test FAILED");
        $finish;
    end

    task automatic check_mem_data(input string name, input mem_data_t got, input mem_data_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_packet(input string name, input packet_t got, input packet_t exp);
        if (got !== exp) begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic write_reg(input mem_addr_t addr, input mem_data_t data);
        @(posedge clk);
        mem_address   <= addr;
        mem_write     <= 1'b1;
        mem_writedata <= data;
        @(posedge clk);
        mem_write <= 1'b0;
    endtask

    task automatic check_reg(input string name, input mem_addr_t addr, input mem_data_t exp);
        @(posedge clk);
        mem_address <= addr;
        @(posedge clk);
        @(negedge clk); // Read data is one cycle behind the address
        check_mem_data(name, mem_readdata, exp);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_n <= 1'b0;
        bp_en   <= 1'b0;
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        out_q.delete();
        exp_q.delete();
        m_lamport  = '0;
        m_user     = '0;
        recv_total = '0;
        sent_total = '0;
    endtask

    task automatic send_packet(input lamport_t lam, input packet_data_t data);
        beat_t beats [BEATS_PER_PACKET];
        beats = '{DEV_ADDR, 32'h0000_0a11, lam, data};
        for (int i = 0; i < BEATS_PER_PACKET; i++) begin
            @(posedge clk);
            input_valid         <= 1'b1;
            input_data          <= beats[i];
            input_startofpacket <= (i == 0);
            input_endofpacket   <= (i == BEATS_PER_PACKET - 1);
            do @(negedge clk); while (!input_ready);
        end
        @(posedge clk);
        input_valid         <= 1'b0;
        input_startofpacket <= 1'b0;
        input_endofpacket   <= 1'b0;
    endtask

    // Reference model of the receive rule
    function automatic void model_receive(input lamport_t lam, input packet_data_t data);
        m_lamport  = ((lam > m_lamport) ? lam : m_lamport) + 1'b1;
        m_user     = m_user + data[15:0];
        recv_total = recv_total + data[15:0];
    endfunction

    // Send call fans the accumulated value out to every target
    function automatic void model_call();
        packet_t pkt;
        m_lamport = m_lamport + 1'b1;
        for (int t = 0; t < NUM_TARGETS; t++) begin
            pkt.dest_addr = TARGET_TABLE[t];
            pkt.src_addr  = {DEV_ADDR[31:8], DEVICE_ID};
            pkt.lamport   = m_lamport;
            pkt.data      = packet_data_t'(m_user);
            exp_q.push_back(pkt);
        end
        m_user = '0;
    endfunction

    task automatic compare_outputs(input bit record, input bit replay);
        packet_t got;
        packet_t exp;
        int      cycles;
        cycles = 0;
        while (out_q.size() < exp_q.size() && cycles < 300) begin
            @(negedge clk);
            cycles++;
        end
        while (exp_q.size() > 0) begin
            exp = exp_q.pop_front();
            if (out_q.size() == 0) begin
                $display("Missing output packet for target %h at %0t", exp.dest_addr, $time);
                errors++;
            end else begin
                got = out_q.pop_front();
                check_packet("output_packet", got, exp);
                if (got.dest_addr == TARGET_TABLE[0]) sent_total = sent_total + got.data[15:0];
                if (record) ref_seq.push_back(got);
                if (replay && ref_idx < ref_seq.size()) begin
                    check_packet("replayed_packet", got, ref_seq[ref_idx]);
                end else if (replay) begin
                    $display("More output packets than in the run without back-pressure");
                    errors++;
                end
                ref_idx++;
            end
        end
    endtask

    task automatic expect_no_output(input int cycles);
        repeat (cycles) @(negedge clk);
        if (out_q.size() != 0) begin
            $display("%0d unexpected output packets at %0t", out_q.size(), $time);
            errors++;
            out_q.delete();
        end
    endtask

    task automatic test_reset_state();
        apply_reset();
        check_reg("reg_state", REG_STATE, DIRCC_STATE_BOOTED);
        check_reg("reg_extra", REG_EXTRA, '0);
        check_reg("reg_user", REG_USER, '0);
        repeat (20) begin
            @(negedge clk);
            if (input_ready) begin
                $display("input_ready high while booted at %0t", $time);
                errors++;
            end
            if (output_valid) begin
                $display("output_valid high after reset at %0t", $time);
                errors++;
            end
        end
    endtask

    task automatic test_single_packet();
        apply_reset();
        write_reg(REG_STATE, DIRCC_STATE_RUNNING);
        send_packet(32'd10, 32'd7);
        model_receive(32'd10, 32'd7);
        model_call();
        compare_outputs(1'b0, 1'b0);
        expect_no_output(20);
        check_reg("reg_extra", REG_EXTRA, '0);
        check_reg("reg_user", REG_USER, '0);
    endtask

    task automatic run_bursts(input bit backpressure);
        int n;
        apply_reset();
        write_reg(REG_STATE, DIRCC_STATE_RUNNING);
        bp_en   <= backpressure;
        ref_idx = 0;
        for (int b = 0; b < BURSTS; b++) begin
            for (int i = 0; i < BURST_LEN; i++) begin
                n = b * BURST_LEN + i;
                send_packet(stim_lamport[n], stim_data[n]);
            end
            // First packet starts a fan-out and the rest of the burst lands inside it
            for (int i = 0; i < BURST_LEN; i++) begin
                n = b * BURST_LEN + i;
                model_receive(stim_lamport[n], stim_data[n]);
                if (i == 0 || i == BURST_LEN - 1) model_call();
            end
            compare_outputs(!backpressure, backpressure);
        end
        expect_no_output(30);
        check_mem_data("payload_total", sent_total, recv_total);
        bp_en <= 1'b0;
    endtask

    task automatic test_stopped();
        apply_reset();
        write_reg(REG_USER, 16'h1234);
        write_reg(REG_STATE, DIRCC_STATE_STOPPED);
        send_packet(32'd3, 32'h0000_0055);
        expect_no_output(50);
        check_reg("reg_state", REG_STATE, DIRCC_STATE_STOPPED | DIRCC_STATE_ERROR);
        check_reg("reg_extra", REG_EXTRA, '0);
        check_reg("reg_user", REG_USER, 16'h1234);
    endtask

    initial begin
        reset_n             = 1'b1;
        address             = DEV_ADDR;
        input_data          = '0;
        input_startofpacket = 1'b0;
        input_endofpacket   = 1'b0;
        input_valid         = 1'b0;
        output_ready        = 1'b1;
        mem_address         = '0;
        mem_write           = 1'b0;
        mem_writedata       = '0;
        bp_en               = 1'b0;
        bp_idx              = '0;
        ref_idx             = 0;
        errors              = 0;
        void'($urandom(32'hda72_e184));
        for (int i = 0; i < NUM_STIM; i++) begin
            stim_data[i]    = $urandom;
            stim_lamport[i] = $urandom;
        end
        for (int k = 0; k < 8; k++) bp_bits[k*32 +: 32] = $urandom;

        test_reset_state();
        test_single_packet();
        run_bursts(1'b0);
        run_bursts(1'b1); // Same stimulus with random output_ready
        test_stopped();

        $display("Errors: %0d check, %0d assertion", errors, i_dircc_processing.i_chk.assert_fails);
        if (errors == 0 && i_dircc_processing.i_chk.assert_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : dircc_processing_tb

`default_nettype wire
